/* Makefile */
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f exec_core.f \
		--top-module tb_exec_core -o tb_exec_core

run: build
	./obj_dir/tb_exec_core > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "Simulation failed"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f exec_core.f --top-module tb_exec_core

clean:
	rm -rf obj_dir $(LOG)

/* alu.sv */
`timescale 1ns/1ps

module alu import wisc_pkg::*; (
	input  word_t      i_a,
	input  word_t      i_b,
	input  alu_op_t    i_op,
	input  logic [1:0] i_set_sel,
	output word_t      o_result,
	output logic       o_set_bit
);

	logic [2*WORD_W-1:0] rot_l;
	logic [2*WORD_W-1:0] rot_r;
	logic [3:0]          shamt;
	word_t               sum;
	word_t               cmp;
	word_t               rev;
	logic                carry_f;
	logic                zero_f;
	logic                neg_f;
	logic                ovf;
	logic                lt;

	assign shamt = i_b[3:0];
	assign rot_l = {i_a, i_a} << shamt;
	assign rot_r = {i_a, i_a} >> shamt;

	assign {carry_f, sum} = i_a + i_b;   // Carry feeds SCO.

	// ---------------------------------------------------------
	// Compare flags from a minus b
	// ---------------------------------------------------------
	assign cmp    = i_a - i_b;
	assign zero_f = (cmp == '0);
	assign neg_f  = cmp[WORD_W-1];
	assign ovf    = (i_a[WORD_W-1] ^ i_b[WORD_W-1]) & (cmp[WORD_W-1] ^ i_a[WORD_W-1]);
	assign lt     = neg_f ^ ovf;

	always_comb begin
		for (int i = 0; i < WORD_W; i++) begin
			rev[i] = i_a[WORD_W-1-i];
		end
	end

	always_comb begin
		case (i_op)
			ALU_ADD:        o_result = sum;
			ALU_SUB:        o_result = i_b - i_a;   // SUB and SUBI take rt or imm minus rs.
			ALU_XOR:        o_result = i_a ^ i_b;
			ALU_ANDN:       o_result = i_a & ~i_b;
			ALU_ROL:        o_result = rot_l[2*WORD_W-1:WORD_W];
			ALU_SLL:        o_result = i_a << shamt;
			ALU_ROR:        o_result = rot_r[WORD_W-1:0];
			ALU_SRL:        o_result = i_a >> shamt;
			ALU_BYTE_SHIFT: o_result = {i_a[7:0], i_b[7:0]};   // Old low byte moves up.
			ALU_CMP:        o_result = cmp;
			ALU_BIT_REV:    o_result = rev;
			default:        o_result = i_a;   // Pass a.
		endcase
	end

	always_comb begin
		case (i_set_sel)
			SET_EQ:    o_set_bit = zero_f;
			SET_LT:    o_set_bit = lt;
			SET_LE:    o_set_bit = lt | zero_f;
			SET_CARRY: o_set_bit = carry_f;
			default:   o_set_bit = 1'b0;
		endcase
	end

endmodule

/* branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import wisc_pkg::*; (
	input  word_t i_pc,
	input  word_t i_rs_data,
	input  word_t i_imm,
	input  word_t i_alu_result,
	input  logic  i_branch_eq,
	input  logic  i_branch_lt,
	input  logic  i_branch_gt,
	input  logic  i_jump,
	input  logic  i_jump_reg,
	input  logic  i_halt,
	output word_t o_next_pc
);

	word_t seq_pc;
	word_t rel_pc;
	logic  rs_zero;
	logic  rs_neg;
	logic  taken;

	assign seq_pc  = i_pc + 16'd2;
	assign rel_pc  = seq_pc + i_imm;
	assign rs_zero = (i_rs_data == '0);
	assign rs_neg  = i_rs_data[WORD_W-1];

	// BNEZ raises lt and gt together, so zero counts as ge only for BGEZ.
	assign taken = (i_branch_eq & rs_zero)
		| (i_branch_lt & rs_neg)
		| (i_branch_gt & ~rs_neg & (~rs_zero | ~i_branch_lt));

	always_comb begin
		if (i_halt) begin
			o_next_pc = i_pc;
		end else if (i_jump_reg) begin
			o_next_pc = i_alu_result;   // rs plus imm.
		end else if (i_jump || taken) begin
			o_next_pc = rel_pc;
		end else begin
			o_next_pc = seq_pc;
		end
	end

endmodule

/* control.sv */
`timescale 1ns/1ps

module control import wisc_pkg::*; (
	input  opcode_t    i_opcode,
	output logic [1:0] o_reg_dst,
	output logic [1:0] o_wb_sel,
	output logic [1:0] o_imm_sel,
	output logic [1:0] o_set_sel,
	output alu_op_t    o_alu_op,
	output logic       o_alu_src,
	output logic       o_reg_write,
	output logic       o_mem_rd,
	output logic       o_mem_wr,
	output logic       o_branch_eq,
	output logic       o_branch_lt,
	output logic       o_branch_gt,
	output logic       o_jump,
	output logic       o_jump_reg,
	output logic       o_set_result,
	output logic       o_halt,
	output logic       o_err
);

	always_comb begin
		// Defaults give a NOP.
		o_reg_dst    = RD_FIELD_LOW;
		o_wb_sel     = WB_ALU;
		o_imm_sel    = IMM_5_SIGNED;
		o_set_sel    = SET_EQ;
		o_alu_op     = ALU_PASS_A;
		o_alu_src    = 1'b0;
		o_reg_write  = 1'b0;
		o_mem_rd     = 1'b0;
		o_mem_wr     = 1'b0;
		o_branch_eq  = 1'b0;
		o_branch_lt  = 1'b0;
		o_branch_gt  = 1'b0;
		o_jump       = 1'b0;
		o_jump_reg   = 1'b0;
		o_set_result = 1'b0;
		o_halt       = 1'b0;
		o_err        = 1'b0;

		casez (i_opcode)
			OP_HALT: begin
				o_halt = 1'b1;
			end
			OP_NOP, OP_SIIC, OP_RTI: begin
				// No exception support.
			end

			// -------------------------------------------------
			// Immediate ALU forms, rd in instr[7:5]
			// -------------------------------------------------
			OP_IMM_ARITH: begin
				o_reg_dst   = RD_FIELD_MID;
				o_alu_src   = 1'b1;
				o_reg_write = 1'b1;
				o_alu_op    = {2'b00, i_opcode[1:0]};
			end
			OP_IMM_LOGIC: begin
				o_reg_dst   = RD_FIELD_MID;
				o_imm_sel   = IMM_5_ZERO;
				o_alu_src   = 1'b1;
				o_reg_write = 1'b1;
				o_alu_op    = {2'b00, i_opcode[1:0]};
			end
			OP_IMM_SHIFT: begin
				o_reg_dst   = RD_FIELD_MID;
				o_imm_sel   = IMM_5_ZERO;
				o_alu_src   = 1'b1;
				o_reg_write = 1'b1;
				o_alu_op    = {2'b01, i_opcode[1:0]};
			end

			OP_ST: begin
				o_alu_src = 1'b1;
				o_alu_op  = ALU_ADD;
				o_mem_wr  = 1'b1;
			end
			OP_LD: begin
				o_reg_dst   = RD_FIELD_MID;
				o_wb_sel    = WB_MEM;
				o_alu_src   = 1'b1;
				o_alu_op    = ALU_ADD;
				o_mem_rd    = 1'b1;
				o_reg_write = 1'b1;
			end
			OP_STU: begin
				o_reg_dst   = RD_FIELD_HIGH;   // Address goes back to rs.
				o_alu_src   = 1'b1;
				o_alu_op    = ALU_ADD;
				o_mem_wr    = 1'b1;
				o_reg_write = 1'b1;
			end

			OP_LBI: begin
				o_reg_dst   = RD_FIELD_HIGH;
				o_wb_sel    = WB_IMM;
				o_imm_sel   = IMM_8_SIGNED;
				o_reg_write = 1'b1;
			end
			OP_SLBI: begin
				o_reg_dst   = RD_FIELD_HIGH;
				o_imm_sel   = IMM_8_SIGNED;
				o_alu_src   = 1'b1;
				o_alu_op    = ALU_BYTE_SHIFT;
				o_reg_write = 1'b1;
			end
			OP_BTR: begin
				o_alu_op    = ALU_BIT_REV;
				o_reg_write = 1'b1;
			end
			OP_ALU1: begin
				// Function bits are merged in by the datapath.
				o_alu_op    = {1'b0, ~i_opcode[0], 2'b00};
				o_reg_write = 1'b1;
			end
			OP_SET: begin
				o_alu_op     = ALU_CMP;
				o_set_sel    = i_opcode[1:0];
				o_set_result = 1'b1;
				o_reg_write  = 1'b1;
			end

			// -------------------------------------------------
			// Branches and jumps
			// -------------------------------------------------
			OP_BEQZ: begin
				o_imm_sel   = IMM_8_SIGNED;
				o_branch_eq = 1'b1;
			end
			OP_BNEZ: begin
				o_imm_sel   = IMM_8_SIGNED;
				o_branch_lt = 1'b1;
				o_branch_gt = 1'b1;
			end
			OP_BLTZ: begin
				o_imm_sel   = IMM_8_SIGNED;
				o_branch_lt = 1'b1;
			end
			OP_BGEZ: begin
				o_imm_sel   = IMM_8_SIGNED;
				o_branch_gt = 1'b1;
			end
			OP_J: begin
				o_imm_sel = IMM_11_SIGNED;
				o_jump    = 1'b1;
			end
			OP_JAL: begin
				o_imm_sel   = IMM_11_SIGNED;
				o_jump      = 1'b1;
				o_reg_dst   = RD_LINK_R7;
				o_wb_sel    = WB_LINK;
				o_reg_write = 1'b1;
			end
			OP_JR: begin
				o_imm_sel  = IMM_8_SIGNED;
				o_alu_src  = 1'b1;
				o_alu_op   = ALU_ADD;
				o_jump     = 1'b1;
				o_jump_reg = 1'b1;
			end
			OP_JALR: begin
				o_imm_sel   = IMM_8_SIGNED;
				o_alu_src   = 1'b1;
				o_alu_op    = ALU_ADD;
				o_jump      = 1'b1;
				o_jump_reg  = 1'b1;
				o_reg_dst   = RD_LINK_R7;
				o_wb_sel    = WB_LINK;
				o_reg_write = 1'b1;
			end
			default: o_err = 1'b1;
		endcase

		a_mem_excl: assert (!(o_mem_rd && o_mem_wr))
			else $error("control: memory read and write both enabled");
	end

endmodule

/* exec_core.f */
wisc_pkg.sv
control.sv
imm_extend.sv
reg_file.sv
alu.sv
branch_unit.sv
exec_core.sv
tb_clk_gen.sv
tb_exec_core.sv

/* exec_core.sv */
`timescale 1ns/1ps

module exec_core import wisc_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  instr_t    i_instr,
	input  word_t     i_pc,
	input  word_t     i_mem_rdata,
	output word_t     o_next_pc,
	output word_t     o_mem_addr,
	output word_t     o_mem_wdata,
	output logic      o_mem_rd,
	output logic      o_mem_wr,
	output logic      o_wb_en,
	output reg_addr_t o_wb_reg,
	output word_t     o_wb_data,
	output logic      o_halt,
	output logic      o_err
);

	opcode_t    opcode;
	logic [1:0] reg_dst;
	logic [1:0] wb_sel;
	logic [1:0] imm_sel;
	logic [1:0] set_sel;
	alu_op_t    ctl_alu_op;
	alu_op_t    alu_op;
	logic       alu_src;
	logic       branch_eq;
	logic       branch_lt;
	logic       branch_gt;
	logic       jump;
	logic       jump_reg;
	logic       set_result;
	logic       set_bit;
	word_t      imm;
	word_t      rs_data;
	word_t      rt_data;
	word_t      alu_b;
	word_t      alu_result;
	word_t      link_pc;

	assign opcode = i_instr[15:11];

	control u_control (
		.i_opcode     (opcode),
		.o_reg_dst    (reg_dst),
		.o_wb_sel     (wb_sel),
		.o_imm_sel    (imm_sel),
		.o_set_sel    (set_sel),
		.o_alu_op     (ctl_alu_op),
		.o_alu_src    (alu_src),
		.o_reg_write  (o_wb_en),
		.o_mem_rd     (o_mem_rd),
		.o_mem_wr     (o_mem_wr),
		.o_branch_eq  (branch_eq),
		.o_branch_lt  (branch_lt),
		.o_branch_gt  (branch_gt),
		.o_jump       (jump),
		.o_jump_reg   (jump_reg),
		.o_set_result (set_result),
		.o_halt       (o_halt),
		.o_err        (o_err)
	);

	imm_extend u_imm_extend (
		.i_instr   (i_instr),
		.i_imm_sel (imm_sel),
		.o_imm     (imm)
	);

	reg_file u_reg_file (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_wr_en     (o_wb_en),
		.i_wr_addr   (o_wb_reg),
		.i_wr_data   (o_wb_data),
		.i_rd_addr_a (i_instr[10:8]),
		.i_rd_addr_b (i_instr[7:5]),
		.o_rd_data_a (rs_data),
		.o_rd_data_b (rt_data)
	);

	// R-format ALU ops carry their function in instr[1:0].
	assign alu_op = (opcode ==? OP_ALU1) ? {ctl_alu_op[3:2], i_instr[1:0]} : ctl_alu_op;
	assign alu_b  = alu_src ? imm : rt_data;

	alu u_alu (
		.i_a       (rs_data),
		.i_b       (alu_b),
		.i_op      (alu_op),
		.i_set_sel (set_sel),
		.o_result  (alu_result),
		.o_set_bit (set_bit)
	);

	branch_unit u_branch_unit (
		.i_pc         (i_pc),
		.i_rs_data    (rs_data),
		.i_imm        (imm),
		.i_alu_result (alu_result),
		.i_branch_eq  (branch_eq),
		.i_branch_lt  (branch_lt),
		.i_branch_gt  (branch_gt),
		.i_jump       (jump),
		.i_jump_reg   (jump_reg),
		.i_halt       (o_halt),
		.o_next_pc    (o_next_pc)
	);

	// ---------------------------------------------------------
	// Memory port and writeback
	// ---------------------------------------------------------
	assign o_mem_addr  = alu_result;
	assign o_mem_wdata = rt_data;
	assign link_pc     = i_pc + 16'd2;

	always_comb begin
		case (reg_dst)
			RD_FIELD_LOW:  o_wb_reg = i_instr[4:2];
			RD_FIELD_MID:  o_wb_reg = i_instr[7:5];
			RD_FIELD_HIGH: o_wb_reg = i_instr[10:8];
			default:       o_wb_reg = LINK_REG;
		endcase
	end

	always_comb begin
		case (wb_sel)
			WB_MEM:  o_wb_data = i_mem_rdata;
			WB_LINK: o_wb_data = link_pc;
			WB_IMM:  o_wb_data = imm;
			default: o_wb_data = set_result ? {{(WORD_W-1){1'b0}}, set_bit} : alu_result;
		endcase
	end

endmodule

/* imm_extend.sv */
`timescale 1ns/1ps

module imm_extend import wisc_pkg::*; (
	input  instr_t     i_instr,
	input  logic [1:0] i_imm_sel,
	output word_t      o_imm
);

	// Field widths follow the I-format 1, I-format 2 and J formats.
	always_comb begin
		case (i_imm_sel)
			IMM_5_SIGNED: begin
				o_imm = {{(WORD_W-5){i_instr[4]}}, i_instr[4:0]};
			end
			IMM_5_ZERO: begin
				o_imm = {{(WORD_W-5){1'b0}}, i_instr[4:0]};
			end
			IMM_8_SIGNED: begin
				o_imm = {{(WORD_W-8){i_instr[7]}}, i_instr[7:0]};
			end
			IMM_11_SIGNED: begin
				o_imm = {{(WORD_W-11){i_instr[10]}}, i_instr[10:0]};
			end
			default: o_imm = '0;
		endcase
	end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file import wisc_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_wr_en,
	input  reg_addr_t i_wr_addr,
	input  word_t     i_wr_data,
	input  reg_addr_t i_rd_addr_a,
	input  reg_addr_t i_rd_addr_b,
	output word_t     o_rd_data_a,
	output word_t     o_rd_data_b
);

	word_t regs [REG_CNT];

	// Writes land on the edge; reads see them from the next cycle on.
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < REG_CNT; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	assign o_rd_data_a = regs[i_rd_addr_a];
	assign o_rd_data_b = regs[i_rd_addr_b];

	a_wr_addr_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_wr_en |-> !$isunknown(i_wr_addr))
		else $error("reg_file: write enabled with unknown address");

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;   // 8 ns period.
	end

	initial begin
		o_rst_n = 1'b0;
		repeat (16) @(posedge o_clk);
		#1 o_rst_n = 1'b1;
	end

endmodule

/* tb_exec_core.sv */
`timescale 1ns/1ps

module tb_exec_core import wisc_pkg::*; ();

	typedef struct packed {
		instr_t    instr;
		word_t     pc;
		word_t     rdata;
		word_t     next_pc;
		logic      wb_en;
		reg_addr_t wb_reg;
		word_t     wb_data;
		logic      mem_rd;
		logic      mem_wr;
		word_t     mem_addr;
		word_t     mem_wdata;
		logic      halt;
	} row_t;

	logic      clk;
	logic      rst_n;
	instr_t    instr;
	word_t     pc;
	word_t     mem_rdata;
	word_t     next_pc;
	word_t     mem_addr;
	word_t     mem_wdata;
	logic      mem_rd;
	logic      mem_wr;
	logic      wb_en;
	reg_addr_t wb_reg;
	word_t     wb_data;
	logic      halt;
	logic      err;

	row_t      rows[$];
	string     names[$];
	int        checks;
	int        errors;
	logic      released;

	tb_clk_gen u_tb_clk_gen (
		.o_clk   (clk),
		.o_rst_n (rst_n)
	);

	exec_core u_exec_core (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_instr     (instr),
		.i_pc        (pc),
		.i_mem_rdata (mem_rdata),
		.o_next_pc   (next_pc),
		.o_mem_addr  (mem_addr),
		.o_mem_wdata (mem_wdata),
		.o_mem_rd    (mem_rd),
		.o_mem_wr    (mem_wr),
		.o_wb_en     (wb_en),
		.o_wb_reg    (wb_reg),
		.o_wb_data   (wb_data),
		.o_halt      (halt),
		.o_err       (err)
	);

	// ---------------------------------------------------------
	// Instruction encoders for the four formats
	// ---------------------------------------------------------
	function automatic instr_t enc_i1(input opcode_t op, input reg_addr_t rs,
			input reg_addr_t rd, input logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic instr_t enc_i2(input opcode_t op, input reg_addr_t rs,
			input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic instr_t enc_r(input opcode_t op, input reg_addr_t rs,
			input reg_addr_t rt, input reg_addr_t rd, input logic [1:0] func);
		return {op, rs, rt, rd, func};
	endfunction

	function automatic instr_t enc_j(input opcode_t op, input logic [10:0] imm);
		return {op, imm};
	endfunction

	task automatic add_row(input string name, input instr_t ins, input word_t row_pc,
			input word_t rdata, input word_t exp_pc, input logic exp_wb,
			input reg_addr_t exp_reg, input word_t exp_data, input logic exp_rd,
			input logic exp_wr, input word_t exp_addr, input word_t exp_wdata,
			input logic exp_halt);
		row_t r;
		r = '{ins, row_pc, rdata, exp_pc, exp_wb, exp_reg, exp_data,
			exp_rd, exp_wr, exp_addr, exp_wdata, exp_halt};
		rows.push_back(r);
		names.push_back(name);
	endtask

	// Register write with a sequential next pc.
	task automatic add_wb(input string name, input instr_t ins, input word_t row_pc,
			input reg_addr_t rd, input word_t data);
		add_row(name, ins, row_pc, 16'h0, row_pc + 16'd2, 1'b1, rd, data,
			1'b0, 1'b0, 16'h0, 16'h0, 1'b0);
	endtask

	task automatic add_flow(input string name, input instr_t ins, input word_t row_pc,
			input word_t exp_pc);
		add_row(name, ins, row_pc, 16'h0, exp_pc, 1'b0, 3'd0, 16'h0,
			1'b0, 1'b0, 16'h0, 16'h0, 1'b0);
	endtask

	task automatic build_table();
		add_flow("nop_after_reset", enc_j(5'b00001, 11'd0), 16'h00FE, 16'h0100);
		// Registers start at zero.
		add_wb("addi", enc_i1(5'b01000, 3'd0, 3'd1, 5'd5), 16'h0100, 3'd1, 16'h0005);
		add_wb("addi_neg", enc_i1(5'b01000, 3'd1, 3'd2, 5'h1D), 16'h0102, 3'd2, 16'h0002);
		add_wb("subi", enc_i1(5'b01001, 3'd1, 3'd3, 5'd12), 16'h0104, 3'd3, 16'h0007);
		add_wb("xori", enc_i1(5'b01010, 3'd3, 3'd4, 5'h1F), 16'h0106, 3'd4, 16'h0018);
		add_wb("andni", enc_i1(5'b01011, 3'd4, 3'd5, 5'h08), 16'h0108, 3'd5, 16'h0010);
		add_wb("lbi", enc_i2(5'b11000, 3'd6, 8'h80), 16'h010A, 3'd6, 16'hFF80);
		add_wb("slbi", enc_i2(5'b10010, 3'd6, 8'h34), 16'h010C, 3'd6, 16'h8034);
		add_wb("roli", enc_i1(5'b10100, 3'd6, 3'd7, 5'd4), 16'h010E, 3'd7, 16'h0348);
		add_wb("slli", enc_i1(5'b10101, 3'd6, 3'd1, 5'd1), 16'h0110, 3'd1, 16'h0068);
		add_wb("rori", enc_i1(5'b10110, 3'd6, 3'd2, 5'd4), 16'h0112, 3'd2, 16'h4803);
		add_wb("srli", enc_i1(5'b10111, 3'd6, 3'd3, 5'd4), 16'h0114, 3'd3, 16'h0803);
		add_wb("btr", enc_r(5'b11001, 3'd5, 3'd0, 3'd4, 2'd0), 16'h0116, 3'd4, 16'h0800);
		add_wb("add", enc_r(5'b11011, 3'd1, 3'd3, 3'd5, 2'd0), 16'h0118, 3'd5, 16'h086B);
		add_wb("sub", enc_r(5'b11011, 3'd1, 3'd3, 3'd1, 2'd1), 16'h011A, 3'd1, 16'h079B);
		add_wb("seq", enc_r(5'b11100, 3'd3, 3'd3, 3'd1, 2'd0), 16'h011C, 3'd1, 16'h0001);
		add_wb("seq_ne", enc_r(5'b11100, 3'd2, 3'd3, 3'd1, 2'd0), 16'h011E, 3'd1, 16'h0000);
		add_wb("slt", enc_r(5'b11101, 3'd6, 3'd3, 3'd1, 2'd0), 16'h0120, 3'd1, 16'h0001);
		add_wb("sle", enc_r(5'b11110, 3'd2, 3'd3, 3'd1, 2'd0), 16'h0122, 3'd1, 16'h0000);
		add_wb("sco", enc_r(5'b11111, 3'd6, 3'd6, 3'd1, 2'd0), 16'h0124, 3'd1, 16'h0001);
		add_wb("sle_eq", enc_r(5'b11110, 3'd3, 3'd3, 3'd1, 2'd0), 16'h0126, 3'd1, 16'h0001);
		// Register forms, shift amount from R3 low bits.
		add_wb("rol", enc_r(5'b11010, 3'd6, 3'd3, 3'd1, 2'd0), 16'h0160, 3'd1, 16'h01A4);
		add_wb("srl", enc_r(5'b11010, 3'd6, 3'd3, 3'd1, 2'd3), 16'h0162, 3'd1, 16'h1006);
		add_wb("xor", enc_r(5'b11011, 3'd5, 3'd3, 3'd1, 2'd2), 16'h0164, 3'd1, 16'h0068);
		add_wb("andn", enc_r(5'b11011, 3'd2, 3'd3, 3'd1, 2'd3), 16'h0166, 3'd1, 16'h4000);

		// ---------------------------------------------------------
		// Memory, with the testbench acting as data memory
		// ---------------------------------------------------------
		add_row("st", enc_i1(5'b10000, 3'd5, 3'd7, 5'd5), 16'h0128, 16'h0000, 16'h012A,
			1'b0, 3'd0, 16'h0000, 1'b0, 1'b1, 16'h0870, 16'h0348, 1'b0);
		add_row("ld", enc_i1(5'b10001, 3'd5, 3'd2, 5'h1F), 16'h012A, 16'hBEEF, 16'h012C,
			1'b1, 3'd2, 16'hBEEF, 1'b1, 1'b0, 16'h086A, 16'h0000, 1'b0);
		add_row("stu", enc_i1(5'b10011, 3'd4, 3'd2, 5'd14), 16'h012C, 16'h0000, 16'h012E,
			1'b1, 3'd4, 16'h080E, 1'b0, 1'b1, 16'h080E, 16'hBEEF, 1'b0);
		add_wb("stu_readback", enc_i1(5'b01000, 3'd4, 3'd3, 5'd0), 16'h012E, 3'd3, 16'h080E);

		// R0 is zero, R5 positive and R6 negative from here on.
		add_flow("beqz_taken", enc_i2(5'b01100, 3'd0, 8'h10), 16'h0200, 16'h0212);
		add_flow("beqz_not", enc_i2(5'b01100, 3'd5, 8'h10), 16'h0212, 16'h0214);
		add_flow("bnez_taken", enc_i2(5'b01101, 3'd5, 8'hF0), 16'h0214, 16'h0206);
		add_flow("bnez_not", enc_i2(5'b01101, 3'd0, 8'hF0), 16'h0206, 16'h0208);
		add_flow("bltz_taken", enc_i2(5'b01110, 3'd6, 8'h08), 16'h0208, 16'h0212);
		add_flow("bltz_not", enc_i2(5'b01110, 3'd5, 8'h08), 16'h0212, 16'h0214);
		add_flow("bgez_taken", enc_i2(5'b01111, 3'd0, 8'h04), 16'h0214, 16'h021A);
		add_flow("bgez_not", enc_i2(5'b01111, 3'd6, 8'h04), 16'h021A, 16'h021C);
		add_flow("j", enc_j(5'b00100, 11'h100), 16'h021C, 16'h031E);
		add_flow("j_back", enc_j(5'b00100, 11'h7F0), 16'h031E, 16'h0310);
		add_row("jal", enc_j(5'b00110, 11'h020), 16'h0310, 16'h0000, 16'h0332,
			1'b1, 3'd7, 16'h0312, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0);
		add_flow("jr", enc_i2(5'b00101, 3'd4, 8'h02), 16'h0332, 16'h0810);
		add_row("jalr", enc_i2(5'b00111, 3'd7, 8'hFE), 16'h0810, 16'h0000, 16'h0310,
			1'b1, 3'd7, 16'h0812, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b0);
		add_wb("jalr_readback", enc_i1(5'b01000, 3'd7, 3'd1, 5'd0), 16'h0310, 3'd1, 16'h0812);
		add_flow("siic", enc_j(5'b00010, 11'd0), 16'h0312, 16'h0314);
		add_flow("rti", enc_j(5'b00011, 11'd0), 16'h0314, 16'h0316);
		add_row("halt", enc_j(5'b00000, 11'd0), 16'h0316, 16'h0000, 16'h0316,
			1'b0, 3'd0, 16'h0000, 1'b0, 1'b0, 16'h0000, 16'h0000, 1'b1);
	endtask

	task automatic check_word(input string name, input string field, input word_t exp,
			input word_t act);
		checks++;
		if (act !== exp) begin
			$display("error %s: %s expected %h actual %h", name, field, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input string field, input logic exp,
			input logic act);
		checks++;
		if (act !== exp) begin
			$display("error %s: %s expected %b actual %b", name, field, exp, act);
			errors++;
		end
	endtask

	task automatic check_row(input string name, input row_t r);
		check_word(name, "o_next_pc", r.next_pc, next_pc);
		check_bit(name, "o_wb_en", r.wb_en, wb_en);
		check_bit(name, "o_mem_rd", r.mem_rd, mem_rd);
		check_bit(name, "o_mem_wr", r.mem_wr, mem_wr);
		check_bit(name, "o_halt", r.halt, halt);
		check_bit(name, "o_err", 1'b0, err);
		if (r.wb_en) begin
			check_word(name, "o_wb_reg", 16'(r.wb_reg), 16'(wb_reg));
			check_word(name, "o_wb_data", r.wb_data, wb_data);
		end
		if (r.mem_rd || r.mem_wr) begin
			check_word(name, "o_mem_addr", r.mem_addr, mem_addr);
		end
		if (r.mem_wr) begin
			check_word(name, "o_mem_wdata", r.mem_wdata, mem_wdata);
		end
	endtask

	task automatic wait_reset_release(output logic ok);
		int cycles;
		cycles = 0;
		while (rst_n !== 1'b1 && cycles < 100) begin
			@(posedge clk);
			cycles++;
		end
		ok = (rst_n === 1'b1);
	endtask

	initial begin
		instr     = 16'h0800;   // NOP.
		pc        = 16'h0000;
		mem_rdata = 16'h0000;
		checks    = 0;
		errors    = 0;
		build_table();

		wait_reset_release(released);
		if (!released) begin
			$display("timeout: reset was never released");
			errors++;
		end else begin
			// Drive 1 ns after the edge, sample 1 ns before the next one.
			for (int i = 0; i < rows.size(); i++) begin
				@(posedge clk);
				#1;
				instr     = rows[i].instr;
				pc        = rows[i].pc;
				mem_rdata = rows[i].rdata;
				#6;
				check_row(names[i], rows[i]);
			end

			// Every 5-bit opcode is assigned, so none may flag o_err.
			for (int op = 0; op < 32; op++) begin
				@(posedge clk);
				#1;
				instr = {5'(op), 11'd0};
				#6;
				check_bit($sformatf("opcode_%02h", op), "o_err", 1'b0, err);
			end
		end

		$display("Checks: %0d, error count: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* wisc_pkg.sv */
package wisc_pkg;

	// ---------------------------------------------------------
	// Widths and vector types
	// ---------------------------------------------------------
	localparam int WORD_W  = 16;
	localparam int REG_CNT = 8;

	typedef logic [WORD_W-1:0]          word_t;
	typedef logic [WORD_W-1:0]          instr_t;
	typedef logic [$clog2(REG_CNT)-1:0] reg_addr_t;
	typedef logic [4:0]                 opcode_t;
	typedef logic [3:0]                 alu_op_t;

	localparam reg_addr_t LINK_REG = 3'd7;

	// ---------------------------------------------------------
	// Opcodes in instr[15:11]
	// ---------------------------------------------------------
	localparam opcode_t OP_HALT      = 5'b00000;
	localparam opcode_t OP_NOP       = 5'b00001;
	localparam opcode_t OP_IMM_ARITH = 5'b0100?;   // ADDI, SUBI.
	localparam opcode_t OP_IMM_LOGIC = 5'b0101?;   // XORI, ANDNI.
	localparam opcode_t OP_IMM_SHIFT = 5'b101??;   // ROLI, SLLI, RORI, SRLI.
	localparam opcode_t OP_ST        = 5'b10000;
	localparam opcode_t OP_LD        = 5'b10001;
	localparam opcode_t OP_STU       = 5'b10011;
	localparam opcode_t OP_BTR       = 5'b11001;
	localparam opcode_t OP_ALU1      = 5'b1101?;   // Low bit set picks add group.
	localparam opcode_t OP_SET       = 5'b111??;   // SEQ, SLT, SLE, SCO.
	localparam opcode_t OP_BEQZ      = 5'b01100;
	localparam opcode_t OP_BNEZ      = 5'b01101;
	localparam opcode_t OP_BLTZ      = 5'b01110;
	localparam opcode_t OP_BGEZ      = 5'b01111;
	localparam opcode_t OP_LBI       = 5'b11000;
	localparam opcode_t OP_SLBI      = 5'b10010;
	localparam opcode_t OP_J         = 5'b00100;
	localparam opcode_t OP_JR        = 5'b00101;
	localparam opcode_t OP_JAL       = 5'b00110;
	localparam opcode_t OP_JALR      = 5'b00111;
	localparam opcode_t OP_SIIC      = 5'b00010;
	localparam opcode_t OP_RTI       = 5'b00011;

	// ALU codes. The two low bits of each group line up with the opcode.
	localparam alu_op_t ALU_ADD        = 4'd0;
	localparam alu_op_t ALU_SUB        = 4'd1;
	localparam alu_op_t ALU_XOR        = 4'd2;
	localparam alu_op_t ALU_ANDN       = 4'd3;
	localparam alu_op_t ALU_ROL        = 4'd4;
	localparam alu_op_t ALU_SLL        = 4'd5;
	localparam alu_op_t ALU_ROR        = 4'd6;
	localparam alu_op_t ALU_SRL        = 4'd7;
	localparam alu_op_t ALU_PASS_A     = 4'd8;
	localparam alu_op_t ALU_BYTE_SHIFT = 4'd9;
	localparam alu_op_t ALU_CMP        = 4'd10;
	localparam alu_op_t ALU_BIT_REV    = 4'd11;

	// ---------------------------------------------------------
	// Datapath selects
	// ---------------------------------------------------------
	localparam logic [1:0] RD_FIELD_LOW  = 2'd0;   // instr[4:2].
	localparam logic [1:0] RD_FIELD_MID  = 2'd1;   // instr[7:5].
	localparam logic [1:0] RD_FIELD_HIGH = 2'd2;   // instr[10:8].
	localparam logic [1:0] RD_LINK_R7    = 2'd3;

	localparam logic [1:0] WB_MEM  = 2'd0;
	localparam logic [1:0] WB_ALU  = 2'd1;
	localparam logic [1:0] WB_LINK = 2'd2;
	localparam logic [1:0] WB_IMM  = 2'd3;

	localparam logic [1:0] IMM_5_SIGNED  = 2'd0;
	localparam logic [1:0] IMM_5_ZERO    = 2'd1;
	localparam logic [1:0] IMM_8_SIGNED  = 2'd2;
	localparam logic [1:0] IMM_11_SIGNED = 2'd3;

	// Same order as the low opcode bits of the set group.
	localparam logic [1:0] SET_EQ    = 2'd0;
	localparam logic [1:0] SET_LT    = 2'd1;
	localparam logic [1:0] SET_LE    = 2'd2;
	localparam logic [1:0] SET_CARRY = 2'd3;

endpackage
